// ==== src/paillier_pkg.sv ====
`default_nettype none

package paillier_pkg;

    localparam int WORD_W    = 32;                       // Modulus, operand and result width
    localparam int BATCH_LEN = 8;                        // Operand pairs and results per task
    localparam int IDX_W     = $clog2(BATCH_LEN + 1);    // Holds a count up to BATCH_LEN
    localparam int PTR_W     = $clog2(BATCH_LEN);        // Operand buffer pointer width
    localparam int BIT_IDX_W = $clog2(WORD_W);           // Bit position inside a word

    typedef logic [WORD_W-1:0] word_t;

    // Codes 00 and 01 are reserved and never start a task
    typedef enum logic [1:0] {
        CMD_ENC_RSVD   = 2'b00,
        CMD_DEC_RSVD   = 2'b01,
        CMD_HOMO_ADD   = 2'b10,
        CMD_SCALAR_MUL = 2'b11
    } task_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_ISSUE,
        ST_WAIT,
        ST_END
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/mod_op_if.sv ====
`default_nettype none

interface mod_op_if;

    logic                start;    // One-cycle request that captures the operands
    paillier_pkg::word_t x;
    paillier_pkg::word_t y;
    paillier_pkg::word_t m;
    paillier_pkg::word_t result;
    logic                done;     // One-cycle pulse with the result valid alongside

    modport ctrl (
        output start,
        output x,
        output y,
        output m,
        input  result,
        input  done
    );

    modport unit (
        input  start,
        input  x,
        input  y,
        input  m,
        output result,
        output done
    );

endinterface

`default_nettype wire

// ==== src/operand_buf.sv ====
`default_nettype none

module operand_buf (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       clear,
    input  wire                       push,
    input  wire  paillier_pkg::word_t push_a,
    input  wire  paillier_pkg::word_t push_b,
    input  wire                       pop,
    output paillier_pkg::word_t       head_a,
    output paillier_pkg::word_t       head_b,
    output logic                      not_empty
);

    paillier_pkg::word_t mem_a [paillier_pkg::BATCH_LEN];
    paillier_pkg::word_t mem_b [paillier_pkg::BATCH_LEN];

    logic [paillier_pkg::PTR_W-1:0] wr_ptr;
    logic [paillier_pkg::PTR_W-1:0] rd_ptr;
    logic [paillier_pkg::PTR_W-1:0] wr_idx;
    logic [paillier_pkg::PTR_W-1:0] wr_next;
    logic [paillier_pkg::PTR_W-1:0] rd_next;
    logic [paillier_pkg::IDX_W-1:0] count;
    logic                           full;

    localparam logic [paillier_pkg::PTR_W-1:0] LAST_PTR =
        paillier_pkg::PTR_W'(paillier_pkg::BATCH_LEN - 1);

    assign wr_idx  = clear ? '0 : wr_ptr;    // A pair arriving with the request lands in slot 0
    assign wr_next = (wr_idx == LAST_PTR) ? '0 : wr_idx + 1'b1;
    assign rd_next = (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
    assign full    = (count == paillier_pkg::IDX_W'(paillier_pkg::BATCH_LEN));

    assign head_a    = mem_a[rd_ptr];
    assign head_b    = mem_b[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem_a[wr_idx] <= push_a;
            mem_b[wr_idx] <= push_b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= push ? wr_next : '0;
            rd_ptr <= '0;
            count  <= push ? paillier_pkg::IDX_W'(1) : '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_next;
            end
            if (pop) begin
                rd_ptr <= rd_next;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !clear) |-> (!full || pop))
        else $error("operand buffer overflow");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty)
        else $error("operand buffer popped while empty");

endmodule

`default_nettype wire

// ==== src/mod_mul_unit.sv ====
`default_nettype none

module mod_mul_unit (
    input wire     clk,
    input wire     rst_n,
    mod_op_if.unit bus
);

    logic                               busy;
    logic                               done_q;
    logic [paillier_pkg::BIT_IDX_W-1:0] bit_cnt;
    paillier_pkg::word_t                x_q;
    paillier_pkg::word_t                y_q;
    paillier_pkg::word_t                m_q;
    logic [paillier_pkg::WORD_W:0]      acc;        // Extra bit holds 2*acc + y before reduction
    logic [paillier_pkg::WORD_W:0]      dbl;
    logic [paillier_pkg::WORD_W:0]      dbl_red;
    logic [paillier_pkg::WORD_W:0]      sum;
    logic [paillier_pkg::WORD_W:0]      sum_red;

    // Each interleaved step computes acc = (2*acc + bit*y) mod m with every partial below m
    always_comb begin
        dbl     = acc << 1;
        dbl_red = (dbl >= {1'b0, m_q}) ? dbl - {1'b0, m_q} : dbl;
        sum     = dbl_red + (x_q[paillier_pkg::WORD_W-1] ? {1'b0, y_q} : '0);
        sum_red = (sum >= {1'b0, m_q}) ? sum - {1'b0, m_q} : sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done_q  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (bus.start) begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == paillier_pkg::BIT_IDX_W'(paillier_pkg::WORD_W - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;    // Lands WORD_W+1 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.start) begin
            x_q <= bus.x;
            y_q <= bus.y;
            m_q <= bus.m;
            acc <= '0;
        end else if (busy) begin
            x_q <= x_q << 1;    // Scan multiplier from the MSB
            acc <= sum_red;
        end
    end

    assign bus.result = acc[paillier_pkg::WORD_W-1:0];
    assign bus.done   = done_q;

    a_mod_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.start && !busy) |-> (bus.m != '0))
        else $error("modular multiply started with zero modulus");

endmodule

`default_nettype wire

// ==== src/mod_exp_unit.sv ====
`default_nettype none

module mod_exp_unit (
    input wire     clk,
    input wire     rst_n,
    mod_op_if.unit bus
);

    typedef enum logic [1:0] {
        EXP_IDLE,
        EXP_SQR,
        EXP_MUL
    } exp_state_e;

    exp_state_e                         state;
    logic                               mm_start;
    logic                               done_q;
    logic                               bit_done;
    logic                               last_bit;
    logic [paillier_pkg::BIT_IDX_W-1:0] bit_cnt;
    paillier_pkg::word_t                base_q;
    paillier_pkg::word_t                exp_q;
    paillier_pkg::word_t                m_q;
    paillier_pkg::word_t                acc_q;

    mod_op_if mm_bus ();

    mod_mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mm_bus)
    );

    assign mm_bus.start = mm_start;
    assign mm_bus.x     = acc_q;
    assign mm_bus.y     = (state == EXP_MUL) ? base_q : acc_q;    // Square or multiply by base
    assign mm_bus.m     = m_q;

    // A bit is finished after its square when clear, or after its multiply when set
    assign bit_done = mm_bus.done
                   && ((state == EXP_MUL)
                       || (state == EXP_SQR && !exp_q[paillier_pkg::WORD_W-1]));
    assign last_bit = (bit_cnt == paillier_pkg::BIT_IDX_W'(paillier_pkg::WORD_W - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EXP_IDLE;
            mm_start <= 1'b0;
            done_q   <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            mm_start <= 1'b0;
            done_q   <= 1'b0;
            if (state == EXP_IDLE) begin
                if (bus.start) begin
                    state    <= EXP_SQR;
                    mm_start <= 1'b1;
                    bit_cnt  <= '0;
                end
            end else if (mm_bus.done && !bit_done) begin
                state    <= EXP_MUL;    // The set exponent bit multiplies in the base
                mm_start <= 1'b1;
            end else if (bit_done) begin
                if (last_bit) begin
                    state  <= EXP_IDLE;
                    done_q <= 1'b1;
                end else begin
                    state    <= EXP_SQR;
                    mm_start <= 1'b1;
                    bit_cnt  <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXP_IDLE && bus.start) begin
            base_q <= bus.x;
            exp_q  <= bus.y;
            m_q    <= bus.m;
            acc_q  <= paillier_pkg::word_t'(1);    // Equals 1 mod m because m is above 1
        end else begin
            if (mm_bus.done) begin
                acc_q <= mm_bus.result;
            end
            if (bit_done) begin
                exp_q <= exp_q << 1;
            end
        end
    end

    assign bus.result = acc_q;
    assign bus.done   = done_q;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        (state != EXP_IDLE) |-> !bus.start)
        else $error("exponentiation restarted while busy");

endmodule

`default_nettype wire

// ==== src/paillier_ctrl.sv ====
`default_nettype none

module paillier_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  paillier_pkg::task_cmd_e task_cmd,
    input  wire                           task_req,
    input  wire  paillier_pkg::word_t     modulus,
    input  wire  paillier_pkg::word_t     head_a,
    input  wire  paillier_pkg::word_t     head_b,
    input  wire                           not_empty,
    output logic                          buf_clear,
    output logic                          pop,
    output paillier_pkg::word_t           res_data,
    output logic                          res_valid,
    output logic                          task_end,
    mod_op_if.ctrl                        mul_bus,
    mod_op_if.ctrl                        exp_bus
);

    paillier_pkg::ctrl_state_e      state;
    paillier_pkg::task_cmd_e        cmd_q;
    paillier_pkg::word_t            mod_q;
    logic [paillier_pkg::IDX_W-1:0] res_cnt;
    logic                           cmd_active;
    logic                           use_mul;
    logic                           unit_done;
    paillier_pkg::word_t            unit_result;

    // Encryption and decryption requests are dropped here
    assign cmd_active = (task_cmd == paillier_pkg::CMD_HOMO_ADD)
                     || (task_cmd == paillier_pkg::CMD_SCALAR_MUL);
    assign use_mul    = (cmd_q == paillier_pkg::CMD_HOMO_ADD);

    assign buf_clear = (state == paillier_pkg::ST_IDLE) && task_req && cmd_active;
    assign pop       = (state == paillier_pkg::ST_ISSUE);

    // Both units see the same operands; only the selected one is started
    assign mul_bus.start = pop && use_mul;
    assign mul_bus.x     = head_a;
    assign mul_bus.y     = head_b;
    assign mul_bus.m     = mod_q;

    assign exp_bus.start = pop && !use_mul;
    assign exp_bus.x     = head_a;    // Base
    assign exp_bus.y     = head_b;    // Exponent
    assign exp_bus.m     = mod_q;

    assign unit_done   = use_mul ? mul_bus.done : exp_bus.done;
    assign unit_result = use_mul ? mul_bus.result : exp_bus.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= paillier_pkg::ST_IDLE;
            cmd_q     <= paillier_pkg::CMD_ENC_RSVD;
            res_cnt   <= '0;
            res_valid <= 1'b0;
            task_end  <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            task_end  <= 1'b0;
            case (state)
                paillier_pkg::ST_IDLE: begin
                    if (buf_clear) begin
                        cmd_q   <= task_cmd;
                        res_cnt <= '0;
                        state   <= paillier_pkg::ST_FETCH;
                    end
                end
                paillier_pkg::ST_FETCH: begin
                    if (not_empty) begin
                        state <= paillier_pkg::ST_ISSUE;
                    end
                end
                paillier_pkg::ST_ISSUE: begin
                    state <= paillier_pkg::ST_WAIT;
                end
                paillier_pkg::ST_WAIT: begin
                    if (unit_done) begin
                        res_valid <= 1'b1;
                        res_cnt   <= res_cnt + 1'b1;
                        if (res_cnt == paillier_pkg::IDX_W'(paillier_pkg::BATCH_LEN - 1)) begin
                            state <= paillier_pkg::ST_END;
                        end else begin
                            state <= paillier_pkg::ST_FETCH;
                        end
                    end
                end
                paillier_pkg::ST_END: begin
                    task_end <= 1'b1;    // One cycle after the last res_valid
                    state    <= paillier_pkg::ST_IDLE;
                end
                default: begin
                    state <= paillier_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (buf_clear) begin
            mod_q <= modulus;
        end
        if (state == paillier_pkg::ST_WAIT && unit_done) begin
            res_data <= unit_result;
        end
    end

    a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        task_req |-> (state == paillier_pkg::ST_IDLE))
        else $error("task_req raised while a task is running");

    a_mul_done_owned: assert property (@(posedge clk) disable iff (!rst_n)
        mul_bus.done |-> (state == paillier_pkg::ST_WAIT && use_mul))
        else $error("done from multiplier that was not started");

    a_exp_done_owned: assert property (@(posedge clk) disable iff (!rst_n)
        exp_bus.done |-> (state == paillier_pkg::ST_WAIT && !use_mul))
        else $error("done from exponentiator that was not started");

endmodule

`default_nettype wire

// ==== src/paillier_top.sv ====
`default_nettype none

module paillier_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  paillier_pkg::task_cmd_e task_cmd,
    input  wire                           task_req,
    input  wire  paillier_pkg::word_t     modulus,
    input  wire  paillier_pkg::word_t     a_data,
    input  wire                           a_valid,
    input  wire  paillier_pkg::word_t     b_data,
    input  wire                           b_valid,
    output paillier_pkg::word_t           res_data,
    output logic                          res_valid,
    output logic                          task_end
);

    logic                buf_clear;
    logic                buf_pop;
    logic                buf_not_empty;
    paillier_pkg::word_t head_a;
    paillier_pkg::word_t head_b;

    mod_op_if mul_bus ();
    mod_op_if exp_bus ();

    operand_buf u_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (buf_clear),
        .push      (a_valid && b_valid),    // Operands travel as a pair
        .push_a    (a_data),
        .push_b    (b_data),
        .pop       (buf_pop),
        .head_a    (head_a),
        .head_b    (head_b),
        .not_empty (buf_not_empty)
    );

    paillier_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .task_cmd  (task_cmd),
        .task_req  (task_req),
        .modulus   (modulus),
        .head_a    (head_a),
        .head_b    (head_b),
        .not_empty (buf_not_empty),
        .buf_clear (buf_clear),
        .pop       (buf_pop),
        .res_data  (res_data),
        .res_valid (res_valid),
        .task_end  (task_end),
        .mul_bus   (mul_bus),
        .exp_bus   (exp_bus)
    );

    mod_mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mul_bus)
    );

    mod_exp_unit u_exp (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (exp_bus)
    );

    // A lone valid would be dropped by the buffer without notice
    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (a_valid || b_valid) |-> (a_valid && b_valid))
        else $error("a_valid and b_valid differ");

endmodule

`default_nettype wire

// ==== testbench/tb_paillier.sv ====
`default_nettype none

module tb_paillier;

    localparam int BATCH        = paillier_pkg::BATCH_LEN;
    localparam int MAX_TASKS    = 16;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_WINDOW  = paillier_pkg::BATCH_LEN * (paillier_pkg::WORD_W + 8);
    localparam int TASK_BUDGET  = paillier_pkg::BATCH_LEN
                                * (2 * paillier_pkg::WORD_W * (paillier_pkg::WORD_W + 2) + 8);

    logic                    clk;
    logic                    rst_n;
    paillier_pkg::task_cmd_e task_cmd;
    logic                    task_req;
    paillier_pkg::word_t     modulus;
    paillier_pkg::word_t     a_data;
    logic                    a_valid;
    paillier_pkg::word_t     b_data;
    logic                    b_valid;
    paillier_pkg::word_t     res_data;
    logic                    res_valid;
    logic                    task_end;

    logic [8*24-1:0]     task_name [MAX_TASKS];
    int                  cmd_code  [MAX_TASKS];
    paillier_pkg::word_t task_mod  [MAX_TASKS];
    int                  task_gap  [MAX_TASKS];
    paillier_pkg::word_t op_a      [MAX_TASKS][BATCH];
    paillier_pkg::word_t op_b      [MAX_TASKS][BATCH];
    paillier_pkg::word_t op_exp    [MAX_TASKS][BATCH];
    int                  n_tasks;

    paillier_pkg::word_t exp_q [$];    // Results still owed by the running task
    paillier_pkg::word_t mon_expected;
    string               cur_name;
    logic                task_active;
    logic                prev_res_valid;
    logic                trace_ok;
    int                  res_count;
    int                  end_count;
    int                  test_errs;
    int                  pass_cnt;
    int                  fail_cnt;
    int                  cycle_limit;
    int                  cycle_cnt;
    integer              seed;

    paillier_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .task_cmd  (task_cmd),
        .task_req  (task_req),
        .modulus   (modulus),
        .a_data    (a_data),
        .a_valid   (a_valid),
        .b_data    (b_data),
        .b_valid   (b_valid),
        .res_data  (res_data),
        .res_valid (res_valid),
        .task_end  (task_end)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Only the homomorphic add and scalar multiply codes start a task
    function automatic logic is_active_cmd(input int code);
        return (code == 2) || (code == 3);
    endfunction

    task automatic load_trace(output logic ok);
        int                  fd;
        int                  r;
        int                  pairs_left;
        int                  cmd_v;
        int                  gap_v;
        string               line;
        logic [8*24-1:0]     name_v;
        paillier_pkg::word_t m_v;
        paillier_pkg::word_t a_v;
        paillier_pkg::word_t b_v;
        paillier_pkg::word_t e_v;
        ok         = 1'b1;
        n_tasks    = 0;
        pairs_left = 0;
        fd = $fopen("testbench/paillier_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file testbench/paillier_trace.txt");
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0 && line.len() > 1 && line[0] != "#") begin
                    if (pairs_left == 0) begin
                        r = $sscanf(line, "%s %d %h %d", name_v, cmd_v, m_v, gap_v);
                        if (r != 4 || n_tasks == MAX_TASKS) begin
                            $display("trace has a bad task line: %s", line);
                            ok = 1'b0;
                        end else begin
                            task_name[n_tasks] = name_v;
                            cmd_code[n_tasks]  = cmd_v;
                            task_mod[n_tasks]  = m_v;
                            task_gap[n_tasks]  = gap_v;
                            n_tasks            = n_tasks + 1;
                            if (is_active_cmd(cmd_v)) begin
                                pairs_left = BATCH;
                            end
                        end
                    end else begin
                        r = $sscanf(line, "%h %h %h", a_v, b_v, e_v);
                        if (r != 3) begin
                            $display("trace has a bad operand line: %s", line);
                            ok = 1'b0;
                        end else begin
                            op_a[n_tasks-1][BATCH-pairs_left]   = a_v;
                            op_b[n_tasks-1][BATCH-pairs_left]   = b_v;
                            op_exp[n_tasks-1][BATCH-pairs_left] = e_v;
                            pairs_left = pairs_left - 1;
                        end
                    end
                end
            end
            if (pairs_left != 0) begin
                $display("trace ends in the middle of a batch");
                ok = 1'b0;
            end
            $fclose(fd);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        task_req = 1'b0;
        a_valid  = 1'b0;
        b_valid  = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic report_test(input logic active);
        if (active && res_count != BATCH) begin
            $display("test %s: got %0d results instead of %0d", cur_name, res_count, BATCH);
            test_errs = test_errs + 1;
        end
        if (active && end_count != 1) begin
            $display("test %s: saw %0d task_end pulses instead of one",
                     cur_name, end_count);
            test_errs = test_errs + 1;
        end
        if (test_errs == 0) begin
            $display("test %s: ok", cur_name);
            pass_cnt = pass_cnt + 1;
        end else begin
            $display("test %s: failed with %0d errors", cur_name, test_errs);
            fail_cnt = fail_cnt + 1;
        end
    endtask

    task automatic run_task(input int t);
        int   code;
        int   gap_len;
        logic active;
        code      = cmd_code[t];
        active    = is_active_cmd(code);
        cur_name  = $sformatf("%0s", task_name[t]);
        test_errs = 0;
        res_count = 0;
        end_count = 0;
        exp_q.delete();
        if (active) begin
            for (int i = 0; i < BATCH; i++) begin
                exp_q.push_back(op_exp[t][i]);
            end
        end
        task_active = active;
        task_cmd    = paillier_pkg::task_cmd_e'(code[1:0]);
        modulus     = task_mod[t];
        task_req    = 1'b1;
        if (!active) begin
            wait_cycles(IDLE_WINDOW);    // Nothing may come out of a reserved request
        end else begin
            for (int i = 0; i < BATCH; i++) begin
                gap_len = 0;
                if (task_gap[t] != 0) begin
                    gap_len = 20 + ($random(seed) & 32'h3F);
                end
                wait_cycles(gap_len);
                a_data  = op_a[t][i];
                b_data  = op_b[t][i];
                a_valid = 1'b1;
                b_valid = 1'b1;
                next_cycle();
            end
            while (end_count == 0) begin
                @(negedge clk);
            end
            wait_cycles(4);    // Catch any output after task_end
        end
        task_active = 1'b0;
        report_test(active);
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (res_valid) begin
                if (!task_active || exp_q.size() == 0) begin
                    $display("test %s: res_valid with no result owed", cur_name);
                    test_errs = test_errs + 1;
                end else begin
                    mon_expected = exp_q.pop_front();
                    if (res_data !== mon_expected) begin
                        $display("error %s: expected %h, actual %h",
                                 cur_name, mon_expected, res_data);
                        test_errs = test_errs + 1;
                    end
                    res_count = res_count + 1;
                end
            end
            if (task_end) begin
                if (!task_active) begin
                    $display("test %s: task_end with no task running", cur_name);
                    test_errs = test_errs + 1;
                end else begin
                    if (end_count != 0) begin
                        $display("test %s: more than one task_end", cur_name);
                        test_errs = test_errs + 1;
                    end else if (!prev_res_valid || res_count != BATCH) begin
                        $display("test %s: task_end not one cycle after the last result",
                                 cur_name);
                        test_errs = test_errs + 1;
                    end
                    end_count = end_count + 1;
                end
            end
            prev_res_valid = res_valid;
        end else begin
            prev_res_valid = 1'b0;
        end
    end

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: test %s still running after %0d cycles", cur_name, cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        task_cmd       = paillier_pkg::CMD_ENC_RSVD;
        task_req       = 1'b0;
        modulus        = '0;
        a_data         = '0;
        a_valid        = 1'b0;
        b_data         = '0;
        b_valid        = 1'b0;
        task_active    = 1'b0;
        prev_res_valid = 1'b0;
        cur_name       = "reset";
        res_count      = 0;
        end_count      = 0;
        test_errs      = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        cycle_limit    = 0;
        seed           = 32'h9015;
        load_trace(trace_ok);
        cycle_limit = n_tasks * TASK_BUDGET + RESET_CYCLES + IDLE_WINDOW;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (trace_ok) begin
            cur_name  = "idle_after_reset";
            test_errs = 0;
            wait_cycles(IDLE_WINDOW);
            report_test(1'b0);
            for (int t = 0; t < n_tasks; t++) begin
                run_task(t);
            end
        end else begin
            fail_cnt = fail_cnt + 1;
        end
        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== paillier.f ====
src/paillier_pkg.sv
src/mod_op_if.sv
src/operand_buf.sv
src/mod_mul_unit.sv
src/mod_exp_unit.sv
src/paillier_ctrl.sv
src/paillier_top.sv
testbench/tb_paillier.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for failure.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_paillier \
    -f paillier.f \
    -Mdir obj_dir \
    -o tb_paillier_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_paillier_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== testbench/paillier_trace.txt ====
# Task line: name, command code (decimal), modulus (hex), gap flag (0 or 1)
# Pair line: a, b, expected (hex); cmd 2 gives a*b mod m, cmd 3 gives a^b mod m
add_basic 2 7fffffff 0
00010000 00010000 00000002
7ffffffe 7ffffffe 00000001
40000000 00000004 00000002
12345678 00000002 2468acf0
7ffffffe 12345678 6dcba987
40000000 40000000 20000000
00010001 00010001 00020003
00000001 7ffffffe 7ffffffe
exp_basic 3 7fffffff 0
00000002 0000001f 00000001
00000002 00000020 00000002
00000002 ffffffff 00000008
12345678 00000000 00000001
00000000 00000005 00000000
7ffffffe ffffffff 7ffffffe
00010000 00000003 00020000
00000003 00000005 000000f3
add_gaps 2 0000fff1 1
00000100 00000100 0000000f
00001000 00001000 00000f00
00008000 00008000 0000c02d
00000002 00000003 00000006
0000fff0 00000001 0000fff0
0000fff0 0000fff0 00000001
00001234 00000010 0000234f
00000000 0000abcd 00000000
rsvd_enc 0 7fffffff 0
rsvd_dec 1 0000fff1 0
add_after_rsvd 2 7fffffff 0
00000100 00000100 00010000
00001000 00001000 01000000
00008000 00008000 40000000
00000002 00000003 00000006
0000fff0 00000001 0000fff0
0000fff0 0000fff0 7fe00101
00001234 00000010 00012340
00000000 0000abcd 00000000
add_small_mod 2 0000fff1 0
00000100 00000100 0000000f
00001000 00001000 00000f00
00008000 00008000 0000c02d
00000002 00000003 00000006
0000fff0 00000001 0000fff0
0000fff0 0000fff0 00000001
00001234 00000010 0000234f
00000000 0000abcd 00000000
